/* run_sim.sh */
#!/usr/bin/env bash
# build the spi master testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module spi_master_tb \
	-f spi_master.f \
	-o spi_master_sim

# keep running after an assertion error so the summary line is printed
./obj_dir/spi_master_sim +verilator+error+limit+1000 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

/* spi_clk_div.sv */
// ---------------------------------------------------------------------
// sclk half period generator
// tick every divisor+1 clocks while run is high, last flags the 16th
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "spi_master_defs.svh"

module spi_clk_div (
	input  logic                  wb_clk_i,
	input  logic                  rst,
	input  logic                  run_i,
	input  logic [`SPI_DIV_W-1:0] divisor_i,
	output logic                  tick_o,
	output logic                  last_o
);

	logic [`SPI_DIV_W-1:0] cnt_q;   // clocks left in this half period
	logic [3:0]            edge_q;  // ticks so far, 0..15

	// ------------------------------------------------------------------
	// half period counter
	// ------------------------------------------------------------------
	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (!run_i) begin
			cnt_q <= divisor_i;       // first tick a full half period after run
		end else if (cnt_q == '0) begin
			cnt_q <= divisor_i;       // reload
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign tick_o = run_i & (cnt_q == '0);

	// ------------------------------------------------------------------
	// edge counter
	// ------------------------------------------------------------------
	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst)
			edge_q <= '0;
		else if (!run_i)
			edge_q <= '0;
		else if (tick_o)
			edge_q <= edge_q + 1'b1;  // wraps after 16
	end

	assign last_o = tick_o & (edge_q == 4'd15);

endmodule

/* spi_master.f */
+incdir+.
spi_master_pkg.sv
spi_regs.sv
spi_xfer_fsm.sv
spi_clk_div.sv
spi_shift_reg.sv
spi_master_top.sv
spi_master_sva.sv
spi_master_tb.sv

/* spi_master_defs.svh */
// ---------------------------------------------------------------------
// spi master widths, register map and control bit positions
// include wherever a width or an address is needed
// ---------------------------------------------------------------------
`ifndef SPI_MASTER_DEFS_SVH
`define SPI_MASTER_DEFS_SVH

// widths
`define SPI_DATA_W 8    // data byte and bus width
`define SPI_DIV_W  16   // sclk divisor
`define SPI_NUM_SS 8    // slave selects

// register addresses on wb_adr_i[2:0]
`define SPI_ADR_CTRL  3'd0
`define SPI_ADR_DIVLO 3'd1
`define SPI_ADR_DIVHI 3'd2
`define SPI_ADR_CS    3'd3
`define SPI_ADR_DATA  3'd4
`define SPI_ADR_STAT  3'd5  // bit 0 tip, bit 1 irq
`define SPI_ADR_CMD   3'd6  // bit 0 starts a byte

// control register bits
`define SPI_CTRL_SPE   0
`define SPI_CTRL_CPOL  1
`define SPI_CTRL_CPHA  2
`define SPI_CTRL_LSBFE 3

`endif

/* spi_master_pkg.sv */
// ---------------------------------------------------------------------
// shared types of the spi master: configuration, shift strobes
// and transfer states
// ---------------------------------------------------------------------
`include "spi_master_defs.svh"

package spi_master_pkg;

	// ------------------------------------------------------------------
	// configuration from the register block
	// ------------------------------------------------------------------
	typedef struct packed {
		logic                  spe;     // core enable
		logic                  cpol;    // sclk idle level
		logic                  cpha;    // 1 = shift on leading edge
		logic                  lsbfe;   // lsb first
		logic [`SPI_DIV_W-1:0] divisor; // half period = divisor+1 clocks
	} spi_cfg_t;

	// ------------------------------------------------------------------
	// per-cycle strobes, fsm to shift register
	// ------------------------------------------------------------------
	typedef struct packed {
		logic load;    // take tx byte
		logic sample;  // capture miso
		logic shift;   // advance one bit
	} spi_shift_t;

	// transfer sequencing
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		SETUP = 2'd1,  // load byte, first bit on mosi
		SHIFT = 2'd2,  // 16 sclk edges
		DONE  = 2'd3   // closing strobe and done pulse
	} spi_state_e;

endpackage

/* spi_master_sva.sv */
// ---------------------------------------------------------------------
// protocol assertions for the spi master, bound into the top level
// bus handshake, idle levels, framing, sclk edge count, interrupt
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "spi_master_defs.svh"

module spi_master_sva (
	input logic                       wb_clk_i,
	input logic                       rst,
	input logic                       wb_cyc_i,
	input logic                       wb_stb_i,
	input logic                       wb_ack_i,
	input logic                       wb_inta_i,
	input logic                       tip_i,
	input logic                       sclk_i,
	input logic [`SPI_NUM_SS-1:0]     ss_n_i,
	input logic [`SPI_NUM_SS-1:0]     cs_i,
	input spi_master_pkg::spi_cfg_t   cfg_i,
	input spi_master_pkg::spi_state_e state_i
);

	// failures per assertion
	int n_ack = 0;
	int n_b2b = 0;
	int n_idle = 0;
	int n_park = 0;
	int n_frame = 0;
	int n_edges = 0;
	int n_irq = 0;
	int n_irq_src = 0;
	int fail_total;
	logic       sclk_q;    // sclk one clock ago
	logic [4:0] edge_cnt;  // sclk edges in the current byte

	assign fail_total = n_ack + n_b2b + n_idle + n_park + n_frame + n_edges + n_irq + n_irq_src;

	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst) begin
			sclk_q   <= 1'b0;
			edge_cnt <= '0;
		end else begin
			sclk_q <= sclk_i;
			if (state_i == spi_master_pkg::SETUP)
				edge_cnt <= '0;             // new byte
			else if (sclk_i != sclk_q)
				edge_cnt <= edge_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// wishbone
	// ------------------------------------------------------------------
	ack_after_req: assert property (@(posedge wb_clk_i) disable iff (rst)
		wb_cyc_i && wb_stb_i && !wb_ack_i |=> wb_ack_i)
		else begin n_ack++; $error("ack missing after cyc and stb"); end

	ack_single: assert property (@(posedge wb_clk_i) disable iff (rst)
		wb_ack_i |=> !wb_ack_i)
		else begin n_b2b++; $error("ack high in two cycles in a row"); end

	// ------------------------------------------------------------------
	// spi framing
	// ------------------------------------------------------------------
	idle_selects: assert property (@(posedge wb_clk_i) disable iff (rst)
		!tip_i |-> ss_n_i == '1)
		else begin n_idle++; $error("slave select active outside a byte"); end

	// sclk follows a new cpol one clock later
	sclk_park: assert property (@(posedge wb_clk_i) disable iff (rst)
		!tip_i && $stable(cfg_i.cpol) |-> sclk_i == cfg_i.cpol)
		else begin n_park++; $error("sclk not at its idle level"); end

	frame_selects: assert property (@(posedge wb_clk_i) disable iff (rst)
		tip_i |-> ss_n_i == ~cs_i)
		else begin n_frame++; $error("slave selects differ from cs during a byte"); end

	edge_count: assert property (@(posedge wb_clk_i) disable iff (rst)
		state_i == spi_master_pkg::IDLE && $past(state_i) == spi_master_pkg::DONE
		|-> edge_cnt == 5'd16)
		else begin n_edges++; $error("byte did not have 16 sclk edges"); end

	// ------------------------------------------------------------------
	// interrupt
	// ------------------------------------------------------------------
	irq_after_tip: assert property (@(posedge wb_clk_i) disable iff (rst)
		$fell(tip_i) |=> wb_inta_i)
		else begin n_irq++; $error("inta did not follow the end of a byte"); end

	irq_source: assert property (@(posedge wb_clk_i) disable iff (rst)
		$rose(wb_inta_i) |-> $past(state_i) == spi_master_pkg::DONE)
		else begin n_irq_src++; $error("inta rose without a finished byte"); end

endmodule

bind spi_master_top spi_master_sva sva_i (
	.wb_clk_i  (wb_clk_i),
	.rst       (rst),
	.wb_cyc_i  (wb_cyc_i),
	.wb_stb_i  (wb_stb_i),
	.wb_ack_i  (wb_ack_o),
	.wb_inta_i (wb_inta_o),
	.tip_i     (tip_o),
	.sclk_i    (sclk_o),
	.ss_n_i    (ss_n_o),
	.cs_i      (cs),
	.cfg_i     (cfg),
	.state_i   (fsm_i.state_q)
);

/* spi_master_tb.sv */
// ---------------------------------------------------------------------
// testbench for the spi master: wishbone tasks, mosi to miso loopback,
// register, transfer and interrupt tests checked by assertions
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "spi_master_defs.svh"

module spi_master_tb;

	localparam int MAX_XFERS      = 20;
	localparam int XFER_CYCLES    = 16 * 4;  // 16 half periods at the largest divisor
	localparam int TIMEOUT_CYCLES = MAX_XFERS * XFER_CYCLES + 1720;

	logic                   wb_clk_i;
	logic                   rst;
	logic [2:0]             wb_adr_i;
	logic [`SPI_DATA_W-1:0] wb_dat_i;
	logic                   wb_we_i;
	logic                   wb_stb_i;
	logic                   wb_cyc_i;
	logic                   miso_i = 1'b0;
	logic [`SPI_DATA_W-1:0] wb_dat_o;
	logic                   wb_ack_o;
	logic                   wb_inta_o;
	logic                   tip_o;
	logic                   sclk_o;
	logic                   mosi_o;
	logic [`SPI_NUM_SS-1:0] ss_n_o;

	int   errors = 0;        // failed tb checks
	int   tests_run = 0;
	int   tests_failed = 0;
	int   faults_at_start;
	int   cycles = 0;
	logic mode_cpol;         // loopback needs the sampling edge
	logic mode_cpha;
	logic sclk_seen = 1'b0;  // sclk at the last falling clock edge

	spi_master_top dut_i (
		.wb_clk_i  (wb_clk_i),
		.rst       (rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_stb_i  (wb_stb_i),
		.wb_cyc_i  (wb_cyc_i),
		.miso_i    (miso_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.wb_inta_o (wb_inta_o),
		.tip_o     (tip_o),
		.sclk_o    (sclk_o),
		.mosi_o    (mosi_o),
		.ss_n_o    (ss_n_o)
	);

	always #2 wb_clk_i = ~wb_clk_i;  // 4 ns period

	// loopback slave takes mosi on the sampling sclk edge and returns it on miso
	always @(negedge wb_clk_i) begin
		if (sclk_o != sclk_seen && sclk_o == ~(mode_cpol ^ mode_cpha))
			miso_i <= mosi_o;
		sclk_seen <= sclk_o;
	end

	// watchdog
	always @(posedge wb_clk_i) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// checks and bookkeeping
	// ------------------------------------------------------------------
	function automatic int fault_count();
		return errors + dut_i.sva_i.fail_total;  // tb checks plus bound assertions
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
	                           input logic [7:0] actual);
		assert (actual === expected)
		else begin
			errors++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic begin_test();
		faults_at_start = fault_count();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (fault_count() != faults_at_start) begin
			tests_failed++;
			$display("%s: failed", name);
		end else
			$display("%s: passed", name);
	endtask

	// ------------------------------------------------------------------
	// wishbone cycles start and end on a falling edge
	// ------------------------------------------------------------------
	task automatic bus_write(input logic [2:0] adr, input logic [7:0] dat);
		wb_adr_i = adr;
		wb_dat_i = dat;
		wb_we_i  = 1'b1;
		wb_stb_i = 1'b1;
		wb_cyc_i = 1'b1;
		do
			@(negedge wb_clk_i);
		while (!wb_ack_o);
		@(negedge wb_clk_i);   // write lands on the rising edge before this
		wb_we_i  = 1'b0;
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
	endtask

	task automatic bus_read(input logic [2:0] adr, output logic [7:0] dat);
		wb_adr_i = adr;
		wb_we_i  = 1'b0;
		wb_stb_i = 1'b1;
		wb_cyc_i = 1'b1;
		do
			@(negedge wb_clk_i);
		while (!wb_ack_o);
		dat = wb_dat_o;        // valid while ack is high
		@(negedge wb_clk_i);
		wb_stb_i = 1'b0;
		wb_cyc_i = 1'b0;
	endtask

	task automatic read_check(input string name, input logic [2:0] adr,
	                          input logic [7:0] expected);
		logic [7:0] dat;
		bus_read(adr, dat);
		check_value(name, expected, dat);
	endtask

	// one byte with loopback; hold keeps the irq pending a while before the clear
	task automatic run_transfer(input string name, input logic cpol, input logic cpha,
	                            input logic lsbfe, input logic [7:0] data, input int div,
	                            input logic [7:0] cs, input int hold);
		int         n;
		logic [7:0] ctrl;
		ctrl = '0;
		ctrl[`SPI_CTRL_SPE]   = 1'b1;
		ctrl[`SPI_CTRL_CPOL]  = cpol;
		ctrl[`SPI_CTRL_CPHA]  = cpha;
		ctrl[`SPI_CTRL_LSBFE] = lsbfe;
		mode_cpol = cpol;
		mode_cpha = cpha;
		bus_write(`SPI_ADR_CTRL, ctrl);
		bus_write(`SPI_ADR_DIVLO, 8'(div));
		bus_write(`SPI_ADR_DIVHI, 8'h00);
		bus_write(`SPI_ADR_CS, cs);
		bus_write(`SPI_ADR_DATA, data);
		bus_write(`SPI_ADR_CMD, 8'h01);
		n = 0;
		while (!tip_o)
			@(negedge wb_clk_i);
		check_value({name, " ss_n"}, ~cs, ss_n_o);  // selects follow the written cs
		while (tip_o) begin
			@(negedge wb_clk_i);
			n++;
		end
		check_value({name, " tip length"}, 8'(17 + 16 * div), 8'(n)); // 1 + 16(div+1)
		@(negedge wb_clk_i);
		check_value({name, " irq set"}, 8'h01, {7'd0, wb_inta_o});
		repeat (hold) @(negedge wb_clk_i);
		check_value({name, " irq held"}, 8'h01, {7'd0, wb_inta_o});
		read_check({name, " status"}, `SPI_ADR_STAT, 8'h02);  // irq set and tip clear
		read_check({name, " data"}, `SPI_ADR_DATA, data);
		bus_write(`SPI_ADR_STAT, 8'h02);
		check_value({name, " irq clear"}, 8'h00, {7'd0, wb_inta_o});
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		int         rnd;
		int         div;
		logic [7:0] data;
		logic [7:0] cs;
		string      name;
		wb_clk_i  = 1'b0;
		rst       = 1'b1;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		wb_we_i   = 1'b0;
		wb_stb_i  = 1'b0;
		wb_cyc_i  = 1'b0;
		mode_cpol = 1'b0;
		mode_cpha = 1'b0;
		rnd = $urandom(1);
		repeat (16) @(negedge wb_clk_i);
		rst = 1'b0;
		@(negedge wb_clk_i);

		begin_test();
		check_value("reset ack", 8'h00, {7'd0, wb_ack_o});
		check_value("reset inta", 8'h00, {7'd0, wb_inta_o});
		check_value("reset tip", 8'h00, {7'd0, tip_o});
		check_value("reset sclk", 8'h00, {7'd0, sclk_o});
		check_value("reset mosi", 8'h00, {7'd0, mosi_o});
		check_value("reset ss_n", 8'hff, ss_n_o);
		end_test("reset_idle");

		// only bits 3:0 of control are kept
		begin_test();
		bus_write(`SPI_ADR_CTRL, 8'hf6);
		read_check("readback ctrl", `SPI_ADR_CTRL, 8'h06);
		data = 8'($urandom);
		bus_write(`SPI_ADR_DIVLO, data);
		read_check("readback divlo", `SPI_ADR_DIVLO, data);
		data = 8'($urandom);
		bus_write(`SPI_ADR_DIVHI, data);
		read_check("readback divhi", `SPI_ADR_DIVHI, data);
		data = 8'($urandom);
		bus_write(`SPI_ADR_CS, data);
		read_check("readback cs", `SPI_ADR_CS, data);
		end_test("reg_readback");

		// all cpol/cpha modes in both bit orders
		for (int m = 0; m < 8; m++) begin
			begin_test();
			data = 8'($urandom);
			div  = $urandom % 4;
			cs   = 8'($urandom);
			name = $sformatf("loopback_cpol%0d_cpha%0d_lsbfe%0d", m[0], m[1], m[2]);
			run_transfer(name, m[0], m[1], m[2], data, div, cs, 0);
			end_test(name);
		end

		begin_test();
		run_transfer("irq", 1'b0, 1'b0, 1'b0, 8'($urandom), 1, 8'h81, 10);
		end_test("irq_sticky_clear");

		// start with the core disabled is dropped
		begin_test();
		bus_write(`SPI_ADR_CTRL, 8'h00);
		bus_write(`SPI_ADR_CMD, 8'h01);
		repeat (8) @(negedge wb_clk_i);
		check_value("spe off tip", 8'h00, {7'd0, tip_o});
		read_check("spe off status", `SPI_ADR_STAT, 8'h00);
		end_test("start_spe_off");

		$display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
		         tests_run, tests_failed, errors, dut_i.sva_i.fail_total);
		if (fault_count() == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* spi_master_top.sv */
// ---------------------------------------------------------------------
// spi master top level with wishbone slave port
// registers, transfer fsm, sclk divider and shift register
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "spi_master_defs.svh"

module spi_master_top (
	input  logic                   wb_clk_i,
	input  logic                   rst,
	input  logic [2:0]             wb_adr_i,
	input  logic [`SPI_DATA_W-1:0] wb_dat_i,
	input  logic                   wb_we_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_cyc_i,
	input  logic                   miso_i,
	output logic [`SPI_DATA_W-1:0] wb_dat_o,
	output logic                   wb_ack_o,
	output logic                   wb_inta_o,
	output logic                   tip_o,
	output logic                   sclk_o,
	output logic                   mosi_o,
	output logic [`SPI_NUM_SS-1:0] ss_n_o
);

	spi_master_pkg::spi_cfg_t   cfg;
	spi_master_pkg::spi_shift_t shift_ctl;
	logic [`SPI_NUM_SS-1:0]     cs;
	logic [`SPI_DATA_W-1:0]     tx_data;
	logic [`SPI_DATA_W-1:0]     rx_data;
	logic                       start;
	logic                       done;
	logic                       tip;
	logic                       run;
	logic                       tick;
	logic                       last;

	// ------------------------------------------------------------------
	// bus side
	// ------------------------------------------------------------------
	spi_regs regs_i (
		.wb_clk_i  (wb_clk_i),
		.rst       (rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_we_i   (wb_we_i),
		.wb_stb_i  (wb_stb_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.wb_inta_o (wb_inta_o),
		.cfg_o     (cfg),
		.cs_o      (cs),
		.tx_data_o (tx_data),
		.start_o   (start),
		.rx_data_i (rx_data),
		.done_i    (done),
		.tip_i     (tip)
	);

	// ------------------------------------------------------------------
	// spi side
	// ------------------------------------------------------------------
	spi_xfer_fsm fsm_i (
		.wb_clk_i (wb_clk_i),
		.rst      (rst),
		.cfg_i    (cfg),
		.start_i  (start),
		.tick_i   (tick),
		.last_i   (last),
		.run_o    (run),
		.shift_o  (shift_ctl),
		.done_o   (done),
		.tip_o    (tip),
		.sclk_o   (sclk_o)
	);

	spi_clk_div div_i (
		.wb_clk_i  (wb_clk_i),
		.rst       (rst),
		.run_i     (run),
		.divisor_i (cfg.divisor),
		.tick_o    (tick),
		.last_o    (last)
	);

	spi_shift_reg sr_i (
		.wb_clk_i  (wb_clk_i),
		.rst       (rst),
		.lsbfe_i   (cfg.lsbfe),
		.ctl_i     (shift_ctl),
		.tx_data_i (tx_data),
		.miso_i    (miso_i),
		.mosi_o    (mosi_o),
		.rx_data_o (rx_data)
	);

	assign ss_n_o = ~(cs & {`SPI_NUM_SS{tip}});  // selects only during a byte
	assign tip_o  = tip;

endmodule

/* spi_regs.sv */
// ---------------------------------------------------------------------
// wishbone register block of the spi master
// single cycle ack, config/cs/tx registers, start command,
// received byte, sticky transfer-complete interrupt
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "spi_master_defs.svh"

module spi_regs (
	input  logic                      wb_clk_i,
	input  logic                      rst,
	input  logic [2:0]                wb_adr_i,
	input  logic [`SPI_DATA_W-1:0]    wb_dat_i,
	input  logic                      wb_we_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_cyc_i,
	output logic [`SPI_DATA_W-1:0]    wb_dat_o,
	output logic                      wb_ack_o,
	output logic                      wb_inta_o,
	output spi_master_pkg::spi_cfg_t  cfg_o,
	output logic [`SPI_NUM_SS-1:0]    cs_o,
	output logic [`SPI_DATA_W-1:0]    tx_data_o,
	output logic                      start_o,
	input  logic [`SPI_DATA_W-1:0]    rx_data_i,
	input  logic                      done_i,
	input  logic                      tip_i
);

	spi_master_pkg::spi_cfg_t cfg_q;
	logic [`SPI_NUM_SS-1:0]   cs_q;
	logic [`SPI_DATA_W-1:0]   tx_q;
	logic [`SPI_DATA_W-1:0]   rx_q;
	logic [`SPI_DATA_W-1:0]   rd_data;
	logic                     ack_q;
	logic                     irq_q;
	logic                     wr;      // write accepted this cycle
	logic                     cfg_wr;  // write allowed into config space

	// ------------------------------------------------------------------
	// bus handshake
	// ------------------------------------------------------------------
	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst)
			ack_q <= 1'b0;
		else
			ack_q <= wb_cyc_i & wb_stb_i & ~ack_q; // one cycle, never back to back
	end

	assign wr     = ack_q & wb_we_i;
	assign cfg_wr = wr & ~tip_i;   // config frozen while a byte runs

	// start only when enabled and idle, otherwise the command is lost
	assign start_o = wr & (wb_adr_i == `SPI_ADR_CMD) & wb_dat_i[0] & cfg_q.spe & ~tip_i;

	// ------------------------------------------------------------------
	// control state
	// ------------------------------------------------------------------
	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst) begin
			cfg_q <= '0;
			cs_q  <= '0;
			irq_q <= 1'b0;
		end else begin
			if (cfg_wr) begin
				case (wb_adr_i)
					`SPI_ADR_CTRL: begin
						cfg_q.spe   <= wb_dat_i[`SPI_CTRL_SPE];
						cfg_q.cpol  <= wb_dat_i[`SPI_CTRL_CPOL];
						cfg_q.cpha  <= wb_dat_i[`SPI_CTRL_CPHA];
						cfg_q.lsbfe <= wb_dat_i[`SPI_CTRL_LSBFE];
					end
					`SPI_ADR_DIVLO: cfg_q.divisor[`SPI_DATA_W-1:0] <= wb_dat_i;
					`SPI_ADR_DIVHI: cfg_q.divisor[`SPI_DIV_W-1:`SPI_DATA_W] <= wb_dat_i;
					`SPI_ADR_CS:    cs_q <= wb_dat_i;
					default: ;
				endcase
			end
			// sticky irq, a new completion beats the clear
			if (done_i)
				irq_q <= 1'b1;
			else if (wr && wb_adr_i == `SPI_ADR_STAT && wb_dat_i[1])
				irq_q <= 1'b0;
		end
	end

	// payload bytes
	always_ff @(posedge wb_clk_i) begin
		if (cfg_wr && wb_adr_i == `SPI_ADR_DATA)
			tx_q <= wb_dat_i;
		if (done_i)
			rx_q <= rx_data_i;  // received byte kept until next done
	end

	// ------------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------------
	always_comb begin
		rd_data = '0;
		case (wb_adr_i)
			`SPI_ADR_CTRL: begin
				rd_data[`SPI_CTRL_SPE]   = cfg_q.spe;
				rd_data[`SPI_CTRL_CPOL]  = cfg_q.cpol;
				rd_data[`SPI_CTRL_CPHA]  = cfg_q.cpha;
				rd_data[`SPI_CTRL_LSBFE] = cfg_q.lsbfe;
			end
			`SPI_ADR_DIVLO: rd_data = cfg_q.divisor[`SPI_DATA_W-1:0];
			`SPI_ADR_DIVHI: rd_data = cfg_q.divisor[`SPI_DIV_W-1:`SPI_DATA_W];
			`SPI_ADR_CS:    rd_data = cs_q;
			`SPI_ADR_DATA:  rd_data = rx_q;
			`SPI_ADR_STAT: begin
				rd_data[0] = tip_i;
				rd_data[1] = irq_q;
			end
			default: rd_data = '0;  // cmd reads zero
		endcase
	end

	assign wb_dat_o  = ack_q ? rd_data : '0;
	assign wb_ack_o  = ack_q;
	assign wb_inta_o = irq_q;
	assign cfg_o     = cfg_q;
	assign cs_o      = cs_q;
	assign tx_data_o = tx_q;

endmodule

/* spi_shift_reg.sv */
// ---------------------------------------------------------------------
// byte shift register for mosi/miso, msb or lsb first
// miso is held on sample and shifted in on the next shift strobe
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`include "spi_master_defs.svh"

module spi_shift_reg (
	input  logic                       wb_clk_i,
	input  logic                       rst,
	input  logic                       lsbfe_i,
	input  spi_master_pkg::spi_shift_t ctl_i,
	input  logic [`SPI_DATA_W-1:0]     tx_data_i,
	input  logic                       miso_i,
	output logic                       mosi_o,
	output logic [`SPI_DATA_W-1:0]     rx_data_o
);

	logic [`SPI_DATA_W-1:0] sr_q, sr_d;
	logic                   hold_q;   // last sampled miso
	logic                   in_bit;

	// sample and shift in the same clock take miso directly
	assign in_bit = ctl_i.sample ? miso_i : hold_q;

	always_comb begin
		sr_d = sr_q;
		if (ctl_i.load)
			sr_d = tx_data_i;
		else if (ctl_i.shift) begin
			if (lsbfe_i)
				sr_d = {in_bit, sr_q[`SPI_DATA_W-1:1]};   // out at bit 0, in at top
			else
				sr_d = {sr_q[`SPI_DATA_W-2:0], in_bit};   // out at top, in at bit 0
		end
	end

	// sr drives mosi, so it idles low after reset
	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst)
			sr_q <= '0;
		else
			sr_q <= sr_d;
	end

	always_ff @(posedge wb_clk_i) begin
		if (ctl_i.sample)
			hold_q <= miso_i;
	end

	assign mosi_o = lsbfe_i ? sr_q[0] : sr_q[`SPI_DATA_W-1];

	// next value, so the done cycle already sees the final cpha=1 bit
	assign rx_data_o = sr_d;

endmodule

/* spi_xfer_fsm.sv */
// ---------------------------------------------------------------------
// transfer fsm: idle, setup, 16 sclk edges, done
// drives sclk and the shift register strobes from the divider ticks
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module spi_xfer_fsm (
	input  logic                       wb_clk_i,
	input  logic                       rst,
	input  spi_master_pkg::spi_cfg_t   cfg_i,
	input  logic                       start_i,
	input  logic                       tick_i,   // half period elapsed
	input  logic                       last_i,   // 16th tick
	output logic                       run_o,
	output spi_master_pkg::spi_shift_t shift_o,
	output logic                       done_o,
	output logic                       tip_o,
	output logic                       sclk_o
);

	spi_master_pkg::spi_state_e state_q, state_d;
	logic sclk_q;
	logic sample_q;   // sample one clock after the sampling edge
	logic first_q;    // no tick seen yet in this byte
	logic odd_tick;   // leading edge of a period
	logic in_shift;

	assign in_shift = (state_q == spi_master_pkg::SHIFT);
	assign odd_tick = (sclk_q == cfg_i.cpol);  // sclk still idle = leading edge

	// ------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			spi_master_pkg::IDLE:  if (start_i) state_d = spi_master_pkg::SETUP;
			spi_master_pkg::SETUP: state_d = spi_master_pkg::SHIFT;
			spi_master_pkg::SHIFT: if (tick_i && last_i) state_d = spi_master_pkg::DONE;
			default:               state_d = spi_master_pkg::IDLE;  // DONE
		endcase
	end

	always_ff @(posedge wb_clk_i or posedge rst) begin
		if (rst) begin
			state_q  <= spi_master_pkg::IDLE;
			sclk_q   <= 1'b0;
			sample_q <= 1'b0;
			first_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			// sclk toggles on ticks, parks at cpol otherwise
			if (in_shift && tick_i)
				sclk_q <= ~sclk_q;
			else if (!in_shift)
				sclk_q <= cfg_i.cpol;
			// cpha=0 samples on odd ticks, cpha=1 on even ticks
			sample_q <= in_shift & tick_i & (odd_tick ^ cfg_i.cpha);
			if (state_q == spi_master_pkg::SETUP)
				first_q <= 1'b1;
			else if (tick_i)
				first_q <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------------
	assign shift_o.load   = (state_q == spi_master_pkg::SETUP);
	assign shift_o.sample = sample_q;
	// shift edge is the other parity; the first cpha=1 edge is covered by the load,
	// the last cpha=1 bit goes in during DONE
	assign shift_o.shift  = (in_shift & tick_i & ~(odd_tick ^ cfg_i.cpha) & ~first_q) |
	                        ((state_q == spi_master_pkg::DONE) & cfg_i.cpha);

	assign run_o  = in_shift;
	assign done_o = (state_q == spi_master_pkg::DONE);
	assign tip_o  = (state_q == spi_master_pkg::SETUP) | in_shift;
	assign sclk_o = sclk_q;

endmodule
